// File: rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // Frame format is 8N1
  localparam int DATA_BITS = 8;

  // One data word on the link
  typedef logic [DATA_BITS-1:0] uart_byte_t;

  // Transmit FSM
  typedef enum logic [2:0] {
    TX_IDLE,   // Line held high, waiting for a send strobe
    TX_START,  // Start bit, line low
    TX_DATA,   // Data bits, LSB first
    TX_STOP,   // Stop bit, line high
    TX_DONE    // One cycle for the done pulse
  } tx_state_t;

  // Receive FSM
  typedef enum logic [1:0] {
    RX_IDLE,   // Waiting for a falling edge
    RX_START,  // Counting to mid start bit
    RX_DATA,   // Sampling data bits
    RX_STOP    // Sampling the stop bit
  } rx_state_t;

endpackage

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  wire logic                 i_Clock,
  input  wire logic                 i_rst_n,
  input  wire logic                 i_tx_dv,
  input  wire uart_pkg::uart_byte_t i_tx_byte,
  output logic                      o_tx_serial,
  output logic                      o_tx_active,
  output logic                      o_tx_done
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(uart_pkg::DATA_BITS);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(uart_pkg::DATA_BITS - 1);

  uart_pkg::tx_state_t  state;
  logic [CNT_W-1:0]     clk_cnt;    // Cycles within the current bit
  logic [IDX_W-1:0]     bit_idx;    // Data bit on the line
  logic [IDX_W-1:0]     next_idx;
  uart_pkg::uart_byte_t tx_data;    // Byte held for the whole frame
  logic                 bit_end;

  assign bit_end  = (clk_cnt == LAST_CNT);
  assign next_idx = bit_idx + 1'b1;

  // Byte is captured with the strobe that starts the frame
  always_ff @(posedge i_Clock)
  begin
    if (state == uart_pkg::TX_IDLE && i_tx_dv)
    begin
      tx_data <= i_tx_byte;
    end
  end

  // Outputs change on state transitions so each bit lasts exactly CLKS_PER_BIT cycles
  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      state       <= uart_pkg::TX_IDLE;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      o_tx_serial <= 1'b1;
      o_tx_active <= 1'b0;
      o_tx_done   <= 1'b0;
    end
    else
    begin
      o_tx_done <= 1'b0;  // Pulse lasts one cycle only

      case (state)
        uart_pkg::TX_IDLE:
        begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (i_tx_dv)
          begin
            o_tx_serial <= 1'b0;  // Start bit from the next cycle
            o_tx_active <= 1'b1;
            state       <= uart_pkg::TX_START;
          end
        end

        uart_pkg::TX_START:
        begin
          if (bit_end)
          begin
            clk_cnt     <= '0;
            o_tx_serial <= tx_data[0];
            state       <= uart_pkg::TX_DATA;
          end
          else
          begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        uart_pkg::TX_DATA:
        begin
          if (bit_end)
          begin
            clk_cnt <= '0;
            if (bit_idx == LAST_BIT)
            begin
              o_tx_serial <= 1'b1;  // Stop bit
              state       <= uart_pkg::TX_STOP;
            end
            else
            begin
              bit_idx     <= next_idx;
              o_tx_serial <= tx_data[next_idx];
            end
          end
          else
          begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        uart_pkg::TX_STOP:
        begin
          if (bit_end)
          begin
            clk_cnt     <= '0;
            o_tx_active <= 1'b0;
            o_tx_done   <= 1'b1;
            state       <= uart_pkg::TX_DONE;
          end
          else
          begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        uart_pkg::TX_DONE:
        begin
          state <= uart_pkg::TX_IDLE;  // Ready for a strobe in the next cycle
        end

        default:
        begin
          state <= uart_pkg::TX_IDLE;
        end
      endcase
    end
  end

  // No strobe while a frame is on the line, it would be dropped
  a_no_dv_while_active : assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    o_tx_active |-> !i_tx_dv)
    else $error("uart_tx: send strobe while frame in progress");

  a_done_not_active : assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    o_tx_done |-> !o_tx_active)
    else $error("uart_tx: done with active high");

  // Idle line must be marking
  a_idle_line_high : assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    (state == uart_pkg::TX_IDLE) |-> o_tx_serial)
    else $error("uart_tx: line low in idle");

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  wire logic            i_Clock,
  input  wire logic            i_rst_n,
  input  wire logic            i_rx_serial,
  output logic                 o_rx_dv,
  output uart_pkg::uart_byte_t o_rx_byte,
  output logic                 o_rx_frame_err
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(uart_pkg::DATA_BITS);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(uart_pkg::DATA_BITS - 1);

  // Line synchronizer
  logic rx_meta;
  logic rx_sync;
  logic rx_sync_d;  // Previous synchronized value, for edge detect
  logic line_fall;

  uart_pkg::rx_state_t  state;
  logic [CNT_W-1:0]     clk_cnt;
  logic [IDX_W-1:0]     bit_idx;
  uart_pkg::uart_byte_t rx_data;  // Assembled LSB first
  logic                 bit_end;

  assign line_fall = rx_sync_d & ~rx_sync;
  assign bit_end   = (clk_cnt == LAST_CNT);
  assign o_rx_byte = rx_data;

  // Two flops against metastability, reset to the idle level
  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      rx_meta   <= 1'b1;
      rx_sync   <= 1'b1;
      rx_sync_d <= 1'b1;
    end
    else
    begin
      rx_meta   <= i_rx_serial;
      rx_sync   <= rx_meta;
      rx_sync_d <= rx_sync;
    end
  end

  // Data shift-in, one sample per bit period
  always_ff @(posedge i_Clock)
  begin
    if (state == uart_pkg::RX_DATA && bit_end)
    begin
      rx_data[bit_idx] <= rx_sync;
    end
  end

  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      state          <= uart_pkg::RX_IDLE;
      clk_cnt        <= '0;
      bit_idx        <= '0;
      o_rx_dv        <= 1'b0;
      o_rx_frame_err <= 1'b0;
    end
    else
    begin
      o_rx_dv        <= 1'b0;
      o_rx_frame_err <= 1'b0;

      case (state)
        uart_pkg::RX_IDLE:
        begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (line_fall)
          begin
            state <= uart_pkg::RX_START;
          end
        end

        // Recheck at half a bit, a high line here means a glitch
        uart_pkg::RX_START:
        begin
          if (clk_cnt == HALF_CNT)
          begin
            clk_cnt <= '0;
            if (rx_sync)
            begin
              state <= uart_pkg::RX_IDLE;
            end
            else
            begin
              state <= uart_pkg::RX_DATA;
            end
          end
          else
          begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        uart_pkg::RX_DATA:
        begin
          if (bit_end)
          begin
            clk_cnt <= '0;
            if (bit_idx == LAST_BIT)
            begin
              state <= uart_pkg::RX_STOP;
            end
            else
            begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
          else
          begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        uart_pkg::RX_STOP:
        begin
          if (bit_end)
          begin
            clk_cnt        <= '0;
            o_rx_dv        <= 1'b1;      // Byte delivered even on a bad stop
            o_rx_frame_err <= ~rx_sync;  // Stop bit must read high
            state          <= uart_pkg::RX_IDLE;
          end
          else
          begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        default:
        begin
          state <= uart_pkg::RX_IDLE;
        end
      endcase
    end
  end

  a_err_with_dv : assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    o_rx_frame_err |-> o_rx_dv)
    else $error("uart_rx: framing error without strobe");

  // Strobe is a single cycle, frames are far longer
  a_dv_single : assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    o_rx_dv |=> !o_rx_dv)
    else $error("uart_rx: receive strobe held two cycles");

endmodule

`default_nettype wire

// File: rtl/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
  parameter int CLKS_PER_BIT = 8
) (
  input  wire logic                 i_Clock,
  input  wire logic                 i_rst_n,

  // Send side
  input  wire logic                 i_tx_dv,
  input  wire uart_pkg::uart_byte_t i_tx_byte,
  output wire logic                 o_tx_serial,
  output wire logic                 o_tx_active,
  output wire logic                 o_tx_done,

  // Receive side, line is asynchronous
  input  wire logic                 i_rx_serial,
  output wire logic                 o_rx_dv,
  output wire uart_pkg::uart_byte_t o_rx_byte,
  output wire logic                 o_rx_frame_err
);

  // Transmitter
  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .i_Clock     (i_Clock),
    .i_rst_n     (i_rst_n),
    .i_tx_dv     (i_tx_dv),
    .i_tx_byte   (i_tx_byte),
    .o_tx_serial (o_tx_serial),
    .o_tx_active (o_tx_active),
    .o_tx_done   (o_tx_done)
  );

  // Receiver, same bit timing as the transmitter
  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .i_Clock        (i_Clock),
    .i_rst_n        (i_rst_n),
    .i_rx_serial    (i_rx_serial),
    .o_rx_dv        (o_rx_dv),
    .o_rx_byte      (o_rx_byte),
    .o_rx_frame_err (o_rx_frame_err)
  );

endmodule

`default_nettype wire

// File: include/uart_tb_cases.svh
`ifndef UART_TB_CASES_SVH
`define UART_TB_CASES_SVH

  // Row columns: mode, random byte, byte, stop bit, expected byte,
  // expected framing flag, expected receive strobe

  localparam logic [1:0] MODE_LOOP   = 2'd0;  // Transmitter looped back to the receiver
  localparam logic [1:0] MODE_FRAME  = 2'd1;  // Frame from the bit driver
  localparam logic [1:0] MODE_GLITCH = 2'd2;  // Short low pulse from the bit driver

  typedef struct packed {
    logic [1:0]           mode;
    logic                 rnd;       // Byte drawn at run time
    uart_pkg::uart_byte_t data;
    logic                 stop_bit;  // Stop level for driven frames
    uart_pkg::uart_byte_t exp_byte;
    logic                 exp_err;
    logic                 exp_dv;
  } tb_case_t;

  localparam int NUM_CASES = 15;

  tb_case_t cases [NUM_CASES];

  task automatic load_cases();
    // Fixed patterns, sent back to back
    cases[0]  = '{MODE_LOOP,   1'b0, 8'h00, 1'b1, 8'h00, 1'b0, 1'b1};
    cases[1]  = '{MODE_LOOP,   1'b0, 8'hFF, 1'b1, 8'hFF, 1'b0, 1'b1};
    cases[2]  = '{MODE_LOOP,   1'b0, 8'h55, 1'b1, 8'h55, 1'b0, 1'b1};
    cases[3]  = '{MODE_LOOP,   1'b0, 8'hA5, 1'b1, 8'hA5, 1'b0, 1'b1};

    // Random bytes, still back to back
    cases[4]  = '{MODE_LOOP,   1'b1, 8'h00, 1'b1, 8'h00, 1'b0, 1'b1};
    cases[5]  = '{MODE_LOOP,   1'b1, 8'h00, 1'b1, 8'h00, 1'b0, 1'b1};
    cases[6]  = '{MODE_LOOP,   1'b1, 8'h00, 1'b1, 8'h00, 1'b0, 1'b1};
    cases[7]  = '{MODE_LOOP,   1'b1, 8'h00, 1'b1, 8'h00, 1'b0, 1'b1};

    cases[8]  = '{MODE_FRAME,  1'b0, 8'h3C, 1'b1, 8'h3C, 1'b0, 1'b1};  // Good stop bit
    cases[9]  = '{MODE_FRAME,  1'b0, 8'hC3, 1'b0, 8'hC3, 1'b1, 1'b1};  // Low stop bit
    cases[10] = '{MODE_GLITCH, 1'b0, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0};
    cases[11] = '{MODE_LOOP,   1'b0, 8'h5A, 1'b1, 8'h5A, 1'b0, 1'b1};  // Recovery after glitch
    cases[12] = '{MODE_FRAME,  1'b0, 8'h81, 1'b0, 8'h81, 1'b1, 1'b1};
    cases[13] = '{MODE_GLITCH, 1'b0, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0};
    cases[14] = '{MODE_LOOP,   1'b1, 8'h00, 1'b1, 8'h00, 1'b0, 1'b1};
  endtask

`endif

// File: dv/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

  localparam int CLKS_PER_BIT  = 8;
  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 10;
  localparam int FRAME_CYCLES  = 10 * CLKS_PER_BIT;
  localparam int GLITCH_CYCLES = CLKS_PER_BIT / 4;  // Well under half a bit
  localparam int SEED          = 96896;

  `include "uart_tb_cases.svh"

  // Each row gets the time of 14 frames
  localparam int WATCHDOG_NS = (NUM_CASES * 14 * FRAME_CYCLES + RESET_CYCLES) * CLK_PERIOD;

  logic                 clk;
  logic                 rst_n;
  logic                 tx_dv;
  uart_pkg::uart_byte_t tx_byte;
  logic                 tx_serial;
  logic                 tx_active;
  logic                 tx_done;
  logic                 rx_serial;
  logic                 rx_dv;
  uart_pkg::uart_byte_t rx_byte;
  logic                 rx_frame_err;

  logic                 line_sel;   // 0 loopback, 1 bit driver
  logic                 drv_line;
  int                   dv_count;   // Receive strobes seen in the current row
  uart_pkg::uart_byte_t dv_byte;
  logic                 dv_err;
  tb_case_t             row;
  uart_pkg::uart_byte_t send_byte;
  uart_pkg::uart_byte_t exp_byte;

  assign rx_serial = line_sel ? drv_line : tx_serial;

  uart_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_dut (
    .i_Clock        (clk),
    .i_rst_n        (rst_n),
    .i_tx_dv        (tx_dv),
    .i_tx_byte      (tx_byte),
    .o_tx_serial    (tx_serial),
    .o_tx_active    (tx_active),
    .o_tx_done      (tx_done),
    .i_rx_serial    (rx_serial),
    .o_rx_dv        (rx_dv),
    .o_rx_byte      (rx_byte),
    .o_rx_frame_err (rx_frame_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Result: FAILED");
    $fatal(1, "Watchdog expired");
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Check failed");
  endtask

  task automatic check_byte(input string name, input uart_pkg::uart_byte_t exp,
                            input uart_pkg::uart_byte_t act);
    if (act !== exp)
    begin
      fail_run($sformatf("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      fail_run($sformatf("Mismatch at %0t: %s expected %b, actual %b", $time, name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      fail_run($sformatf("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp, act));
    end
  endtask

  // Advance to the next falling edge and record any receive strobe
  task automatic watch_cycle();
    @(negedge clk);
    if (rx_dv)
    begin
      dv_count = dv_count + 1;
      dv_byte  = rx_byte;
      dv_err   = rx_frame_err;
    end
  endtask

  task automatic drive_bit(input logic value);
    drv_line = value;
    repeat (CLKS_PER_BIT) watch_cycle();
  endtask

  // Strobe on this falling edge, return on the edge after the done pulse
  task automatic send_loopback(input uart_pkg::uart_byte_t value);
    int active_cnt;
    active_cnt = 0;
    line_sel   = 1'b0;
    tx_dv      = 1'b1;
    tx_byte    = value;
    watch_cycle();
    tx_dv = 1'b0;
    while (tx_active)
    begin
      check_bit("o_tx_done", 1'b0, tx_done);
      active_cnt = active_cnt + 1;
      watch_cycle();
    end
    check_count("o_tx_active cycles", FRAME_CYCLES, active_cnt);
    check_bit("o_tx_done", 1'b1, tx_done);
    watch_cycle();
    check_bit("o_tx_done", 1'b0, tx_done);  // Next strobe may go out here
  endtask

  task automatic send_frame(input uart_pkg::uart_byte_t value, input logic stop);
    int wait_cnt;
    wait_cnt = 0;
    line_sel = 1'b1;
    drive_bit(1'b0);
    for (int b = 0; b < uart_pkg::DATA_BITS; b++)
    begin
      drive_bit(value[b]);
    end
    drive_bit(stop);
    drv_line = 1'b1;
    while (dv_count == 0 && wait_cnt < FRAME_CYCLES)
    begin
      watch_cycle();
      wait_cnt = wait_cnt + 1;
    end
    drive_bit(1'b1);  // Idle bit so the next start edge is seen
  endtask

  task automatic send_glitch();
    line_sel = 1'b1;
    drv_line = 1'b0;
    repeat (GLITCH_CYCLES) watch_cycle();
    drv_line = 1'b1;
    repeat (FRAME_CYCLES) watch_cycle();
  endtask

  initial
  begin
    rst_n    = 1'b0;
    tx_dv    = 1'b0;
    tx_byte  = '0;
    line_sel = 1'b0;
    drv_line = 1'b1;
    dv_count = 0;
    dv_byte  = '0;
    dv_err   = 1'b0;
    void'($urandom(SEED));
    load_cases();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_bit("o_tx_serial", 1'b1, tx_serial);
    check_bit("o_tx_active", 1'b0, tx_active);
    check_bit("o_tx_done", 1'b0, tx_done);
    check_bit("o_rx_dv", 1'b0, rx_dv);
    check_bit("o_rx_frame_err", 1'b0, rx_frame_err);

    for (int i = 0; i < NUM_CASES; i++)
    begin
      row       = cases[i];
      send_byte = row.data;
      exp_byte  = row.exp_byte;
      if (row.rnd)
      begin
        send_byte = uart_pkg::uart_byte_t'($urandom());
        exp_byte  = send_byte;  // Loopback returns the byte unchanged
      end
      dv_count = 0;

      case (row.mode)
        MODE_LOOP:  send_loopback(send_byte);
        MODE_FRAME: send_frame(send_byte, row.stop_bit);
        default:    send_glitch();
      endcase

      if (row.exp_dv)
      begin
        if (dv_count == 0)
        begin
          fail_run($sformatf("Row %0d: no receive strobe for byte %h", i, send_byte));
        end
        check_count("o_rx_dv pulses", 1, dv_count);
        check_byte("o_rx_byte", exp_byte, dv_byte);
        check_bit("o_rx_frame_err", row.exp_err, dv_err);
      end
      else
      begin
        check_count("o_rx_dv pulses", 0, dv_count);
      end
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
dv/uart_tb.sv
